// File: src/dec_div_settings.svh
// Build-time settings for the BCD integer divider
// Digit count and the derived binary and count widths
`ifndef DEC_DIV_SETTINGS_SVH
`define DEC_DIV_SETTINGS_SVH

// Number of decimal digits in each operand and result
`define DEC_DIV_DIGITS 8

// Binary width that holds the largest value of DIGITS nines
// Eight nines need 27 bits (99999999 < 2**27)
`define DEC_DIV_BIN_W 27

// Width of the leading zero digit count
// It has to hold the value DIGITS for an all-zero quotient
`define DEC_DIV_LZ_W 4

`endif

// File: src/dec_div_pkg.sv
// Shared types for the BCD integer divider
// Operand, result and count types plus the controller state encoding
`include "dec_div_settings.svh"

package dec_div_pkg;

	// ================================================
	// Data types
	// ================================================

	// Packed BCD word, four bits per digit, most significant digit on top
	typedef logic [`DEC_DIV_DIGITS*4-1:0] bcd_t;

	// Binary form of one BCD word
	typedef logic [`DEC_DIV_BIN_W-1:0] bin_t;

	// Leading zero digit count of the quotient
	typedef logic [`DEC_DIV_LZ_W-1:0] lz_t;

	// ================================================
	// Controller states
	// ================================================

	// One operation at a time, each stage waits for its done levels
	typedef enum logic [2:0] {
		ST_IDLE     = 3'd0,
		ST_CONV_IN  = 3'd1,
		ST_DIVIDE   = 3'd2,
		ST_CONV_OUT = 3'd3,
		ST_HOLD     = 3'd4
	} ctrl_state_t;

endpackage

// File: src/bcd_to_bin.sv
// Packed BCD to binary converter
// Takes one digit per cycle, most significant digit first
`timescale 1ns/100ps
`include "dec_div_settings.svh"

module bcd_to_bin
	import dec_div_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  bcd_t bcd,
	output bin_t bin,
	output logic done
);

	localparam int CNT_W = $clog2(`DEC_DIV_DIGITS + 1);

	logic [CNT_W-1:0] cnt;
	logic             busy;
	logic [3:0]       digit;
	bcd_t             shreg;
	bin_t             acc;

	// A nonzero count means digits are still waiting in the shift register
	assign busy = (cnt != '0);

	// The outgoing digit always sits in the top nibble
	assign digit = shreg[$bits(bcd_t)-1 -: 4];

	// Digit counter and done level
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt  <= '0;
			done <= 1'b0;
		end
		else if (start)
		begin
			cnt  <= CNT_W'(`DEC_DIV_DIGITS);
			done <= 1'b0;
		end
		else if (busy)
		begin
			cnt <= cnt - 1'b1;
			// Last digit goes in on this edge
			if (cnt == CNT_W'(1))
				done <= 1'b1;
		end
	end

	// Accumulator times ten is acc*8 + acc*2, then the new digit is added
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			shreg <= bcd;
			acc   <= '0;
		end
		else if (busy)
		begin
			shreg <= shreg << 4;
			acc   <= (acc << 3) + (acc << 1) + bin_t'(digit);
		end
	end

	assign bin = acc;

endmodule

// File: src/bin_divider.sv
// Iterative radix-2 restoring divider
// Produces one quotient bit per cycle, most significant bit first,
// and flags a zero divisor at start
`timescale 1ns/100ps
`include "dec_div_settings.svh"

module bin_divider
	import dec_div_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  bin_t dividend,
	input  bin_t divisor,
	output bin_t quotient,
	output bin_t remainder,
	output logic div_by_zero,
	output logic done
);

	localparam int W     = `DEC_DIV_BIN_W;
	localparam int CNT_W = $clog2(W + 1);

	logic [CNT_W-1:0] cnt;
	logic             busy;
	logic             dbz;
	bin_t             quo;
	bin_t             rem;
	bin_t             dvs;
	logic [W:0]       shifted;
	logic [W+1:0]     trial;
	logic             neg;

	assign busy = (cnt != '0);

	// Partial remainder gains the next dividend bit from the top of quo
	assign shifted = {rem, quo[W-1]};

	// Trial subtraction with one spare bit that shows the sign
	assign trial = {1'b0, shifted} - {2'b00, dvs};
	assign neg   = trial[W+1];

	// Bit counter, done level and the zero divisor flag
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt  <= '0;
			done <= 1'b0;
			dbz  <= 1'b0;
		end
		else if (start)
		begin
			cnt  <= CNT_W'(W);
			done <= 1'b0;
			dbz  <= (divisor == '0);
		end
		else if (busy)
		begin
			cnt <= cnt - 1'b1;
			if (cnt == CNT_W'(1))
				done <= 1'b1;
		end
	end

	// quo shifts dividend bits out at the top and quotient bits in at the bottom
	// A zero divisor still runs the full count and yields all ones
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			quo <= dividend;
			rem <= '0;
			dvs <= divisor;
		end
		else if (busy)
		begin
			if (!neg)
			begin
				rem <= trial[W-1:0];
				quo <= {quo[W-2:0], 1'b1};
			end
			else
			begin
				// Restore, keep the shifted remainder as it was
				rem <= shifted[W-1:0];
				quo <= {quo[W-2:0], 1'b0};
			end
		end
	end

	assign quotient    = quo;
	assign remainder   = rem;
	assign div_by_zero = dbz;

endmodule

// File: src/bin_to_bcd.sv
// Binary to packed BCD converter using double dabble
// Shifts in one binary bit per cycle, most significant bit first
`timescale 1ns/100ps
`include "dec_div_settings.svh"

module bin_to_bcd
	import dec_div_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  bin_t bin,
	output bcd_t bcd,
	output logic done
);

	localparam int W     = `DEC_DIV_BIN_W;
	localparam int D     = `DEC_DIV_DIGITS;
	localparam int CNT_W = $clog2(W + 1);

	logic [CNT_W-1:0] cnt;
	logic             busy;
	bin_t             shreg;
	bcd_t             bcd_r;
	bcd_t             adj;

	assign busy = (cnt != '0);

	// Any digit of five or more gets three added before the shift,
	// so that the doubling carries into the next digit correctly
	always_comb
	begin
		adj = bcd_r;
		for (int i = 0; i < D; i++)
		begin
			if (bcd_r[i*4 +: 4] > 4'd4)
				adj[i*4 +: 4] = bcd_r[i*4 +: 4] + 4'd3;
		end
	end

	// Bit counter and done level
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt  <= '0;
			done <= 1'b0;
		end
		else if (start)
		begin
			cnt  <= CNT_W'(W);
			done <= 1'b0;
		end
		else if (busy)
		begin
			cnt <= cnt - 1'b1;
			if (cnt == CNT_W'(1))
				done <= 1'b1;
		end
	end

	// Adjusted BCD word shifts left and takes the top binary bit
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			shreg <= bin;
			bcd_r <= '0;
		end
		else if (busy)
		begin
			bcd_r <= {adj[$bits(bcd_t)-2:0], shreg[W-1]};
			shreg <= shreg << 1;
		end
	end

	assign bcd = bcd_r;

endmodule

// File: src/dec_div.sv
// Unsigned BCD integer divider, top level
// Converts both operands to binary, divides, converts quotient and remainder
// back to BCD and reports the leading zero digits and divide by zero
`timescale 1ns/100ps
`include "dec_div_settings.svh"

module dec_div
	import dec_div_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic in_valid,
	output logic in_ready,
	input  bcd_t a,
	input  bcd_t b,
	output logic out_valid,
	input  logic out_ready,
	output bcd_t q,
	output bcd_t r,
	output lz_t  lzcnt,
	output logic div_by_zero
);

	ctrl_state_t state;
	logic        start_in;
	logic        start_div;
	logic        start_out;
	logic        accept;
	logic        conv_out_fin;

	bcd_t a_r;
	bcd_t b_r;
	bin_t bin_a;
	bin_t bin_b;
	bin_t bin_q;
	bin_t bin_r;
	bcd_t bcd_q;
	bcd_t bcd_r;
	bcd_t q_sel;
	bcd_t r_sel;
	lz_t  lz_next;
	logic seen_nz;
	logic dbz;
	logic done_a;
	logic done_b;
	logic done_div;
	logic done_q;
	logic done_r;

	// ================================================
	// Datapath blocks
	// ================================================

	bcd_to_bin u_conv_a (
		.clk(clk), .arst_n(arst_n), .start(start_in),
		.bcd(a_r), .bin(bin_a), .done(done_a)
	);

	bcd_to_bin u_conv_b (
		.clk(clk), .arst_n(arst_n), .start(start_in),
		.bcd(b_r), .bin(bin_b), .done(done_b)
	);

	bin_divider u_div (
		.clk(clk), .arst_n(arst_n), .start(start_div),
		.dividend(bin_a), .divisor(bin_b),
		.quotient(bin_q), .remainder(bin_r),
		.div_by_zero(dbz), .done(done_div)
	);

	bin_to_bcd u_conv_q (
		.clk(clk), .arst_n(arst_n), .start(start_out),
		.bin(bin_q), .bcd(bcd_q), .done(done_q)
	);

	bin_to_bcd u_conv_r (
		.clk(clk), .arst_n(arst_n), .start(start_out),
		.bin(bin_r), .bcd(bcd_r), .done(done_r)
	);

	// ================================================
	// Sequencing
	// ================================================

	// Operands are taken only while idle
	assign in_ready  = (state == ST_IDLE);
	assign out_valid = (state == ST_HOLD);
	assign accept    = in_valid && in_ready;

	// Done levels of the last stage still read high in the start cycle,
	// so every stage also waits for its own start pulse to drop
	assign conv_out_fin = (state == ST_CONV_OUT) && !start_out && done_q && done_r;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= ST_IDLE;
			start_in  <= 1'b0;
			start_div <= 1'b0;
			start_out <= 1'b0;
		end
		else
		begin
			// Start signals are single cycle pulses
			start_in  <= 1'b0;
			start_div <= 1'b0;
			start_out <= 1'b0;
			case (state)
				ST_IDLE:
					if (accept)
					begin
						state    <= ST_CONV_IN;
						start_in <= 1'b1;
					end
				ST_CONV_IN:
					if (!start_in && done_a && done_b)
					begin
						state     <= ST_DIVIDE;
						start_div <= 1'b1;
					end
				ST_DIVIDE:
					if (!start_div && done_div)
					begin
						state     <= ST_CONV_OUT;
						start_out <= 1'b1;
					end
				ST_CONV_OUT:
					if (conv_out_fin)
						state <= ST_HOLD;
				// Wait here for the result to be taken
				ST_HOLD:
					if (out_ready)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// ================================================
	// Results
	// ================================================

	// A zero divisor forces both results to zero
	assign q_sel = dbz ? '0 : bcd_q;
	assign r_sel = dbz ? '0 : bcd_r;

	// Count zero digits from the top until the first nonzero one
	always_comb
	begin
		lz_next = '0;
		seen_nz = 1'b0;
		for (int i = `DEC_DIV_DIGITS - 1; i >= 0; i--)
		begin
			if (q_sel[i*4 +: 4] != 4'd0)
				seen_nz = 1'b1;
			if (!seen_nz)
				lz_next = lz_next + 1'b1;
		end
	end

	// Operands load on the accepting edge, results on entry to hold
	// Results stay put for the whole hold state
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			a_r <= a;
			b_r <= b;
		end
		if (conv_out_fin)
		begin
			q           <= q_sel;
			r           <= r_sel;
			lzcnt       <= lz_next;
			div_by_zero <= dbz;
		end
	end

endmodule

// File: verification/tb_clock_gen.sv
// Clock source for the BCD divider testbench
// Free-running square wave with a configurable period
`timescale 1ns/100ps

module tb_clock_gen #(
	// Full clock period in ns
	parameter int PERIOD = 40
)(
	output logic clk
);

	// Starts low so that the first rising edge comes half a period in
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

// File: verification/dec_div_asserts.sv
// Handshake and reset assertions for the BCD integer divider
// Bound into every dec_div instance
`timescale 1ns/100ps

module dec_div_asserts
	import dec_div_pkg::*;
(
	input logic        clk,
	input logic        arst_n,
	input logic        in_ready,
	input logic        out_valid,
	input logic        out_ready,
	input bcd_t        q,
	input bcd_t        r,
	input lz_t         lzcnt,
	input logic        div_by_zero,
	input ctrl_state_t state
);

	// Only one operation in flight, so both sides are never open together
	a_one_side_open: assert property (@(posedge clk) disable iff (!arst_n)
		!(in_ready && out_valid))
		else $error("in_ready and out_valid are high together");

	// A result that is not taken stays exactly as it was
	a_result_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && !out_ready) |=> ($stable(q) && $stable(r) && $stable(lzcnt)
			&& $stable(div_by_zero) && out_valid))
		else $error("Result changed or dropped under back-pressure");

	// No result is offered while reset is applied
	a_reset_no_valid: assert property (@(posedge clk) !arst_n |-> !out_valid)
		else $error("out_valid is high during reset");

	// A taken result sends the controller back to idle, ready for the next operand
	a_idle_after_take: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && out_ready) |=> ((state == ST_IDLE) && in_ready))
		else $error("Controller did not return to idle after a result was taken");

endmodule

// Attach the checker to the divider top level
bind dec_div dec_div_asserts u_asserts (
	.clk(clk), .arst_n(arst_n), .in_ready(in_ready), .out_valid(out_valid),
	.out_ready(out_ready), .q(q), .r(r), .lzcnt(lzcnt),
	.div_by_zero(div_by_zero), .state(state)
);

// File: verification/dec_div_tb.sv
// Testbench for the unsigned BCD integer divider
// Reads operands and expected results from the pattern file, applies random
// output back-pressure and checks every result in pattern order
`timescale 1ns/100ps

module dec_div_tb
	import dec_div_pkg::*;
();

	localparam int N_PAT           = 14;
	localparam int N_COL           = 6;
	// Upper bound of 80 cycles per operation, doubled for back-pressure
	localparam int WATCHDOG_CYCLES = (N_PAT + 2) * 80 * 2;

	logic clk;
	logic arst_n;
	logic in_valid;
	logic in_ready;
	bcd_t a;
	bcd_t b;
	logic out_valid;
	logic out_ready;
	bcd_t q;
	bcd_t r;
	lz_t  lzcnt;
	logic div_by_zero;

	// Columns: a, b, q, r, lzcnt, div_by_zero
	logic [31:0] pat_mem [0:N_PAT*N_COL-1];
	integer      seed;
	int          error_count;
	int          check_count;
	int          result_count;

	// ================================================
	// Clock and DUT
	// ================================================

	tb_clock_gen #(.PERIOD(40)) u_clk_gen (.clk(clk));

	dec_div UUT (
		.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .in_ready(in_ready), .a(a), .b(b),
		.out_valid(out_valid), .out_ready(out_ready),
		.q(q), .r(r), .lzcnt(lzcnt), .div_by_zero(div_by_zero)
	);

	// ================================================
	// Checking
	// ================================================

	task automatic check_field(input string name, input int idx,
		input logic [31:0] expected, input logic [31:0] actual);
		check_count++;
		assert (actual === expected)
		else
		begin
			error_count++;
			$display("CHECK FAILED %s (pattern %0d): expected 0x%0h, actual 0x%0h",
				name, idx, expected, actual);
		end
	endtask

	// Compare the result on the output with one line of the pattern file
	task automatic check_result(input int idx);
		check_field("q", idx, pat_mem[idx*N_COL+2], q);
		check_field("r", idx, pat_mem[idx*N_COL+3], r);
		check_field("lzcnt", idx, pat_mem[idx*N_COL+4], 32'(lzcnt));
		check_field("div_by_zero", idx, pat_mem[idx*N_COL+5], 32'(div_by_zero));
	endtask

	// Outputs are sampled on the falling edge, half a cycle away from any change
	// A transfer takes place on the rising edge that follows
	always @(negedge clk)
	begin
		if (arst_n && out_valid && out_ready)
		begin
			if (result_count < N_PAT)
				check_result(result_count);
			else
			begin
				error_count++;
				$display("Result taken after the last pattern was already done");
			end
			result_count++;
		end
	end

	// ================================================
	// Stimulus
	// ================================================

	// Random back-pressure, ready on about half of the cycles
	initial
	begin
		logic [31:0] rnd;
		forever
		begin
			@(posedge clk);
			rnd = $random(seed);
			out_ready <= rnd[0];
		end
	end

	initial
	begin
		$readmemh("verification/dec_div_patterns.txt", pat_mem);
		seed         = 89065;
		error_count  = 0;
		check_count  = 0;
		result_count = 0;
		arst_n       = 1'b0;
		in_valid     = 1'b0;
		a            = '0;
		b            = '0;
		out_ready    = 1'b0;

		@(negedge clk);
		check_field("out_valid", 0, 32'h0, 32'(out_valid));
		// Reset is released after two rising edges
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_field("in_ready", 0, 32'h1, 32'(in_ready));
		check_field("out_valid", 0, 32'h0, 32'(out_valid));

		for (int i = 0; i < N_PAT; i++)
		begin
			@(posedge clk);
			in_valid <= 1'b1;
			a        <= pat_mem[i*N_COL+0];
			b        <= pat_mem[i*N_COL+1];
			do
				@(negedge clk);
			while (!in_ready);
			// Every earlier result must be gone before the next operand goes in
			check_field("results taken", i, 32'(i), 32'(result_count));
			@(posedge clk);
			in_valid <= 1'b0;
		end

		wait (result_count == N_PAT);
		repeat (4) @(posedge clk);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog for a DUT that stops answering
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		error_count++;
		$display("Timeout after %0d cycles with %0d of %0d results taken",
			WATCHDOG_CYCLES, result_count, N_PAT);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: verification/dec_div_patterns.txt
// Columns: dividend a, divisor b, quotient q, remainder r, lzcnt, div_by_zero
// All values in hex, operands and results in packed BCD
00000144 00000012 00000012 00000000 6 0
99999999 00000007 14285714 00000001 0 0
00000005 00000009 00000000 00000005 8 0
12345678 00000000 00000000 00000000 8 1
00000000 00000003 00000000 00000000 8 0
99999999 00000001 99999999 00000000 0 0
99999999 99999999 00000001 00000000 7 0
87654321 00001234 00071032 00000833 3 0
00001000 00000010 00000100 00000000 5 0
00000100 00000007 00000014 00000002 6 0
50000000 00000003 16666666 00000002 0 0
00000000 00000000 00000000 00000000 8 1
12345678 00000100 00123456 00000078 2 0
98765432 12345678 00000008 00000008 7 0

// File: sim.f
+incdir+src
src/dec_div_pkg.sv
src/bcd_to_bin.sv
src/bin_divider.sv
src/bin_to_bcd.sv
src/dec_div.sv
verification/tb_clock_gen.sv
verification/dec_div_asserts.sv
verification/dec_div_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the BCD divider testbench with Verilator
# Exits nonzero unless the log holds the passing verdict

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module dec_div_tb \
	-Mdir "$BUILD_DIR" -o dec_div_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/dec_div_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
	exit 0
fi
echo "Passing verdict not found in $LOG"
exit 1
